//--- common/mac_tx_settings.svh
`ifndef MAC_TX_SETTINGS_SVH
`define MAC_TX_SETTINGS_SVH

// payload beat width, one byte per beat
`define MAC_TX_DATA_W 8

// buffer depths, powers of two
`define MAC_TX_BYTE_FIFO_DEPTH 2048
`define MAC_TX_DESC_FIFO_DEPTH 8

// byte count of one frame
`define MAC_TX_LEN_W 16

// preamble byte
`define MAC_TX_PREAMBLE 8'h55

// 802.3br continuation smd codes
`define MAC_TX_SMD_C0 8'h61
`define MAC_TX_SMD_C1 8'h52
`define MAC_TX_SMD_C2 8'h9E
`define MAC_TX_SMD_C3 8'h2A

// gap after reset, statistics width
`define MAC_TX_IPG_DEFAULT 8'd12
`define MAC_TX_CNT_W 16

`endif

//--- common/mac_tx_frame_pkg.sv
`include "mac_tx_settings.svh"

package mac_tx_frame_pkg;

    // start or continuation code, sent in header byte 6 or 7
    typedef logic [7:0] smd_t;

    // fragment number, only sent after a continuation code
    typedef logic [7:0] frag_t;

    ////////////////////
    // frame descriptor
    ////////////////////

    // one entry per buffered frame, taken from the last input beat
    typedef struct packed {
        logic [`MAC_TX_LEN_W-1:0] len;
        smd_t                     smd;
        frag_t                    frag;
        // low selects mcrc
        logic                     crc_final;
    } frame_desc_t;

    // true for the four continuation codes
    function automatic logic is_cont_smd(smd_t smd);
        return (smd == `MAC_TX_SMD_C0) ||
               (smd == `MAC_TX_SMD_C1) ||
               (smd == `MAC_TX_SMD_C2) ||
               (smd == `MAC_TX_SMD_C3);
    endfunction

endpackage

//--- common/mac_tx_stream_pkg.sv
`include "mac_tx_settings.svh"

package mac_tx_stream_pkg;

    // input beat, preemption fields only valid with last
    typedef struct packed {
        logic [`MAC_TX_DATA_W-1:0] data;
        logic                      last;
        mac_tx_frame_pkg::smd_t    smd;
        mac_tx_frame_pkg::frag_t   frag;
        logic                      crc_final;
    } send_beat_t;

    // output beat, last marks the final fcs byte
    typedef struct packed {
        logic [`MAC_TX_DATA_W-1:0] data;
        logic                      last;
    } tx_beat_t;

    // inter-packet gap, gap taken when load is high
    typedef struct packed {
        logic [7:0] gap;
        logic       load;
    } ipg_cfg_t;

endpackage

//--- hw/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo
#(
    parameter type entry_t = logic [7:0],
    parameter int  DEPTH   = 16
)
(
    input  logic   i_clk,
    input  logic   i_rst,
    input  logic   i_wr_en,
    input  entry_t i_din,
    input  logic   i_rd_en,
    output entry_t o_dout,
    output logic   o_full,
    output logic   o_empty
);

    localparam int AW = $clog2(DEPTH);

    entry_t      mem [DEPTH];
    // extra msb tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        do_wr;
    logic        do_rd;

    assign o_empty = (wr_ptr == rd_ptr);
    assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
    // writes while full and reads while empty are dropped
    assign do_wr   = i_wr_en && !o_full;
    assign do_rd   = i_rd_en && !o_empty;
    // fall-through, head entry visible without a read
    assign o_dout  = mem[rd_ptr[AW-1:0]];

    always_ff @(posedge i_clk)
    begin
        if (do_wr)
            mem[wr_ptr[AW-1:0]] <= i_din;
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (do_wr)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_rd)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- hw/mac_tx_ingress.sv
`timescale 1ns/1ps
`include "mac_tx_settings.svh"

module mac_tx_ingress
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  mac_tx_stream_pkg::send_beat_t i_send,
    input  logic                          i_send_valid,
    input  logic                          i_byte_full,
    input  logic                          i_desc_full,
    output logic                          o_send_ready,
    output logic                          o_byte_wr,
    output logic [`MAC_TX_DATA_W-1:0]     o_byte_data,
    output logic                          o_desc_wr,
    output mac_tx_frame_pkg::frame_desc_t o_desc
);

    // bytes of the frame in progress, before this beat
    logic [`MAC_TX_LEN_W-1:0] byte_cnt;
    logic                     accept;

    // stall while either buffer is full
    assign o_send_ready = !i_byte_full && !i_desc_full;
    assign accept       = i_send_valid && o_send_ready;

    // every byte goes straight into the byte fifo
    assign o_byte_wr   = accept;
    assign o_byte_data = i_send.data;

    // descriptor lands with the last byte, count includes it
    assign o_desc_wr        = accept && i_send.last;
    assign o_desc.len       = byte_cnt + 1'b1;
    assign o_desc.smd       = i_send.smd;
    assign o_desc.frag      = i_send.frag;
    assign o_desc.crc_final = i_send.crc_final;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            byte_cnt <= '0;
        else if (accept)
            // restart on each frame boundary
            byte_cnt <= i_send.last ? '0 : byte_cnt + 1'b1;
    end

endmodule

//--- framer/crc32_d8.sv
`timescale 1ns/1ps

module crc32_d8
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_clear,
    input  logic        i_en,
    input  logic [7:0]  i_data,
    output logic [31:0] o_fcs
);

    logic [31:0] crc;

    // reflected 0x04C11DB7, one bit per step, lsb first
    function automatic logic [31:0] crc_step(logic [31:0] c, logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++)
            r = r[0] ? ((r >> 1) ^ 32'hEDB88320) : (r >> 1);
        return r;
    endfunction

    // final complement, byte 0 goes out first
    assign o_fcs = ~crc;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            crc <= '1;
        // clear wins, it marks the start of a new frame
        else if (i_clear)
            crc <= '1;
        else if (i_en)
            crc <= crc_step(crc, i_data);
    end

endmodule

//--- framer/mac_tx_framer.sv
`timescale 1ns/1ps
`include "mac_tx_settings.svh"

module mac_tx_framer
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  mac_tx_frame_pkg::frame_desc_t i_desc,
    input  logic                          i_desc_empty,
    input  logic [`MAC_TX_DATA_W-1:0]     i_byte,
    input  logic                          i_tx_ready,
    input  mac_tx_stream_pkg::ipg_cfg_t   i_ipg,
    output logic                          o_desc_rd,
    output logic                          o_byte_rd,
    output mac_tx_stream_pkg::tx_beat_t   o_tx,
    output logic                          o_tx_valid,
    output logic [`MAC_TX_CNT_W-1:0]      o_tx_frames_cnt,
    output logic [`MAC_TX_CNT_W-1:0]      o_tx_fragment_cnt
);

    // one spare bit covers header and fcs on top of the length
    localparam int POS_W = `MAC_TX_LEN_W + 1;

    mac_tx_frame_pkg::frame_desc_t cur_desc;
    logic                      busy;
    logic [POS_W-1:0]          pos;
    logic [POS_W-1:0]          pay_end;
    logic [POS_W-1:0]          last_pos;
    logic [1:0]                fcs_idx;
    logic                      in_payload;
    logic                      cur_cont;
    logic                      start;
    logic [7:0]                gap_len;
    logic [7:0]                gap_cnt;
    logic                      gap_ok;
    logic [31:0]               fcs;
    logic [7:0]                fcs_byte;
    logic [`MAC_TX_DATA_W-1:0] next_byte;

    ////////////////////
    // frame positions
    ////////////////////

    // header 0..7, payload 8..pay_end-1, fcs after
    assign pay_end    = {1'b0, cur_desc.len} + POS_W'(8);
    assign last_pos   = pay_end + POS_W'(3);
    assign in_payload = busy && (pos >= POS_W'(8)) && (pos < pay_end);
    assign fcs_idx    = 2'(pos - pay_end);
    assign cur_cont   = mac_tx_frame_pkg::is_cont_smd(cur_desc.smd);

    // gap_cnt lags the idle run on o_tx_valid by one
    assign gap_ok = ({1'b0, gap_cnt} + 9'd1) >= {1'b0, gap_len};
    // ready only sampled here, the frame then runs to the end
    assign start  = !busy && !i_desc_empty && i_tx_ready && gap_ok;

    // descriptor popped at start, bytes during payload
    assign o_desc_rd = start;
    assign o_byte_rd = in_payload;

    crc32_d8 crc_i
    (
        .i_clk  (i_clk),
        .i_rst  (i_rst),
        .i_clear(start),
        .i_en   (in_payload),
        .i_data (i_byte),
        .o_fcs  (fcs)
    );

    // wire order lsb first, upper half flipped for mcrc
    always_comb
    begin
        fcs_byte = fcs[8*fcs_idx +: 8];
        if (fcs_idx[1] && !cur_desc.crc_final)
            fcs_byte = ~fcs_byte;
    end

    // continuation: smd at byte 6, fragment number at byte 7
    always_comb
    begin
        if (pos < POS_W'(6))
            next_byte = `MAC_TX_PREAMBLE;
        else if (pos == POS_W'(6))
            next_byte = cur_cont ? cur_desc.smd : `MAC_TX_PREAMBLE;
        else if (pos == POS_W'(7))
            next_byte = cur_cont ? cur_desc.frag : cur_desc.smd;
        else if (in_payload)
            next_byte = i_byte;
        else
            next_byte = fcs_byte;
    end

    always_ff @(posedge i_clk)
    begin
        if (start)
            cur_desc <= i_desc;
    end

    ////////////////////
    // sequencer
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            busy       <= 1'b0;
            pos        <= '0;
            o_tx       <= '0;
            o_tx_valid <= 1'b0;
        end
        else
        begin
            if (start)
            begin
                busy <= 1'b1;
                pos  <= '0;
            end
            else if (busy)
            begin
                busy <= (pos != last_pos);
                pos  <= pos + 1'b1;
            end
            // output one cycle behind the position
            o_tx.data  <= next_byte;
            o_tx.last  <= busy && (pos == last_pos);
            o_tx_valid <= busy;
        end
    end

    ////////////////////
    // gap and stats
    ////////////////////

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            gap_len           <= `MAC_TX_IPG_DEFAULT;
            // saturated so the first frame need not wait
            gap_cnt           <= '1;
            o_tx_frames_cnt   <= '0;
            o_tx_fragment_cnt <= '0;
        end
        else
        begin
            if (i_ipg.load)
                gap_len <= i_ipg.gap;
            if (busy)
                gap_cnt <= '0;
            else if (gap_cnt != 8'hFF)
                gap_cnt <= gap_cnt + 1'b1;
            if (start)
            begin
                o_tx_frames_cnt <= o_tx_frames_cnt + 1'b1;
                if (mac_tx_frame_pkg::is_cont_smd(i_desc.smd))
                    o_tx_fragment_cnt <= o_tx_fragment_cnt + 1'b1;
            end
        end
    end

endmodule

//--- hw/mac_tx.sv
`timescale 1ns/1ps
`include "mac_tx_settings.svh"

module mac_tx
(
    input  logic                          i_clk,
    input  logic                          i_rst,
    input  mac_tx_stream_pkg::send_beat_t i_send,
    input  logic                          i_send_valid,
    input  logic                          i_tx_ready,
    input  mac_tx_stream_pkg::ipg_cfg_t   i_ipg,
    output logic                          o_send_ready,
    output mac_tx_stream_pkg::tx_beat_t   o_tx,
    output logic                          o_tx_valid,
    output logic [`MAC_TX_CNT_W-1:0]      o_tx_frames_cnt,
    output logic [`MAC_TX_CNT_W-1:0]      o_tx_fragment_cnt
);

    logic                          byte_wr, byte_rd, byte_full;
    logic [`MAC_TX_DATA_W-1:0]     byte_din, byte_dout;
    logic                          desc_wr, desc_rd, desc_full, desc_empty;
    mac_tx_frame_pkg::frame_desc_t desc_din, desc_dout;

    // input side, counts bytes and builds descriptors
    mac_tx_ingress ingress_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_send(i_send), .i_send_valid(i_send_valid),
        .i_byte_full(byte_full), .i_desc_full(desc_full), .o_send_ready(o_send_ready),
        .o_byte_wr(byte_wr), .o_byte_data(byte_din), .o_desc_wr(desc_wr), .o_desc(desc_din)
    );

    // payload bytes of all queued frames
    // a queued descriptor means all its bytes are already here
    sync_fifo #(.entry_t(logic [`MAC_TX_DATA_W-1:0]), .DEPTH(`MAC_TX_BYTE_FIFO_DEPTH)) byte_fifo_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_wr_en(byte_wr), .i_din(byte_din), .i_rd_en(byte_rd),
        .o_dout(byte_dout), .o_full(byte_full), .o_empty()
    );

    // one entry per complete frame
    sync_fifo #(.entry_t(mac_tx_frame_pkg::frame_desc_t), .DEPTH(`MAC_TX_DESC_FIFO_DEPTH)) desc_fifo_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_wr_en(desc_wr), .i_din(desc_din), .i_rd_en(desc_rd),
        .o_dout(desc_dout), .o_full(desc_full), .o_empty(desc_empty)
    );

    mac_tx_framer framer_i
    (
        .i_clk(i_clk), .i_rst(i_rst), .i_desc(desc_dout), .i_desc_empty(desc_empty),
        .i_byte(byte_dout), .i_tx_ready(i_tx_ready), .i_ipg(i_ipg), .o_desc_rd(desc_rd),
        .o_byte_rd(byte_rd), .o_tx(o_tx), .o_tx_valid(o_tx_valid),
        .o_tx_frames_cnt(o_tx_frames_cnt), .o_tx_fragment_cnt(o_tx_fragment_cnt)
    );

endmodule

//--- verification/mac_tx_tb.sv
`timescale 1ns/1ps
`include "mac_tx_settings.svh"

module mac_tx_tb;

    // 14 frames, each 12 header and fcs bytes on top of the payload
    localparam int NUM_FRAMES  = 14;
    localparam int MAX_LEN     = 64;
    localparam int MAX_GAP     = 30;
    localparam int CYCLE_LIMIT = 2 * (3 + NUM_FRAMES * (12 + MAX_LEN + MAX_GAP));
    // express and preemptable start codes
    localparam logic [7:0] SMD_E  = 8'hD5;
    localparam logic [7:0] SMD_S0 = 8'hE6;

    logic                          i_clk;
    logic                          i_rst;
    mac_tx_stream_pkg::send_beat_t i_send;
    logic                          i_send_valid;
    logic                          i_tx_ready;
    mac_tx_stream_pkg::ipg_cfg_t   i_ipg;
    logic                          o_send_ready;
    mac_tx_stream_pkg::tx_beat_t   o_tx;
    logic                          o_tx_valid;
    logic [`MAC_TX_CNT_W-1:0]      o_tx_frames_cnt;
    logic [`MAC_TX_CNT_W-1:0]      o_tx_fragment_cnt;

    integer     seed;
    int         mon_errors;
    int         stim_errors;
    int         tests_run;
    int         sent_frames;
    int         cycles;
    int         idle_run;
    int         frames_seen;
    int         min_gap;
    logic       hold_low;
    logic       prev_valid;
    logic       prev_last;
    logic [7:0] exp_byte;
    logic       exp_last;
    // expected wire bytes of all submitted frames
    logic [7:0] exp_q [$];
    logic       last_q [$];

    mac_tx mac_tx_i (.*);

    initial
    begin
        i_clk = 1'b0;
        forever #20 i_clk = ~i_clk;
    end

    ////////////////////
    // reference model
    ////////////////////

    // bitwise 802.3 crc, reflected poly, data lsb first
    function automatic logic [31:0] crc_update(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        logic        fb;
        int          k;
        r = c;
        for (k = 0; k < 8; k++)
        begin
            fb = r[0] ^ d[k];
            r  = r >> 1;
            if (fb)
                r = r ^ 32'hEDB88320;
        end
        return r;
    endfunction

    function automatic logic is_continuation(input logic [7:0] smd);
        case (smd)
            `MAC_TX_SMD_C0, `MAC_TX_SMD_C1, `MAC_TX_SMD_C2, `MAC_TX_SMD_C3: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic int rand_len();
        return 1 + int'($unsigned($random(seed)) % MAX_LEN);
    endfunction

    task automatic show_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got == exp)
        else
        begin
            show_mismatch(name, got, exp);
            stim_errors++;
        end
    endtask

    // queue the expected bytes, then push the beats into the dut
    task automatic send_frame(input int len, input logic [7:0] smd, input logic [7:0] frag,
                              input logic crc_final);
        logic [7:0]  payload [$];
        logic [31:0] crc;
        logic [7:0]  b;
        int          i;
        crc = '1;
        for (i = 0; i < 6; i++)
        begin
            exp_q.push_back(`MAC_TX_PREAMBLE);
            last_q.push_back(1'b0);
        end
        exp_q.push_back(is_continuation(smd) ? smd : `MAC_TX_PREAMBLE);
        exp_q.push_back(is_continuation(smd) ? frag : smd);
        last_q.push_back(1'b0);
        last_q.push_back(1'b0);
        for (i = 0; i < len; i++)
        begin
            b = 8'($random(seed));
            payload.push_back(b);
            crc = crc_update(crc, b);
            exp_q.push_back(b);
            last_q.push_back(1'b0);
        end
        // complemented fcs, lsb first, upper half flipped again for mcrc
        crc = ~crc;
        for (i = 0; i < 4; i++)
        begin
            b = crc[8*i +: 8];
            exp_q.push_back((i >= 2 && !crc_final) ? ~b : b);
            last_q.push_back(i == 3);
        end
        for (i = 0; i < len; i++)
        begin
            i_send.data      = payload[i];
            i_send.last      = (i == len - 1);
            i_send.smd       = smd;
            i_send.frag      = frag;
            i_send.crc_final = crc_final;
            i_send_valid     = 1'b1;
            do
                @(posedge i_clk);
            while (!o_send_ready);
            #1;
        end
        i_send_valid = 1'b0;
        sent_frames++;
    endtask

    // done when the model is empty and the line is idle
    task automatic wait_drain();
        do
        begin
            @(posedge i_clk);
            #1;
        end
        while (exp_q.size() != 0 || o_tx_valid);
    endtask

    task automatic load_gap(input logic [7:0] g);
        i_ipg.gap  = g;
        i_ipg.load = 1'b1;
        @(posedge i_clk);
        #1;
        i_ipg.load = 1'b0;
        min_gap    = int'(g);
    endtask

    task automatic finish_test(input string name, input int errs_before);
        tests_run++;
        if (mon_errors + stim_errors == errs_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: failed", tests_run, name);
    endtask

    ////////////////////
    // output monitor
    ////////////////////

    always @(posedge i_clk)
    begin
        if (!i_rst)
        begin
            cycles++;
            if (cycles > CYCLE_LIMIT)
            begin
                $display("timeout, run still busy after %0d cycles", cycles);
                $display(">>> FAIL");
                $finish;
            end
            else
            begin
                // no gaps inside a frame
                assert (o_tx_valid || !prev_valid || prev_last)
                else
                begin
                    $display("o_tx_valid dropped before the last fcs byte");
                    mon_errors++;
                end
                assert (!(hold_low && o_tx_valid))
                else
                begin
                    $display("frame went out while i_tx_ready was held low");
                    mon_errors++;
                end
                if (o_tx_valid && !prev_valid)
                begin
                    if (frames_seen > 0)
                        assert (idle_run >= min_gap)
                        else
                        begin
                            $display("only %0d idle cycles before a frame, gap is %0d",
                                     idle_run, min_gap);
                            mon_errors++;
                        end
                    frames_seen++;
                end
                if (o_tx_valid && exp_q.size() == 0)
                begin
                    $display("output byte while the model expects nothing");
                    mon_errors++;
                end
                else if (o_tx_valid)
                begin
                    exp_byte = exp_q.pop_front();
                    exp_last = last_q.pop_front();
                    assert (o_tx.data == exp_byte)
                    else
                    begin
                        show_mismatch("o_tx.data", 32'(o_tx.data), 32'(exp_byte));
                        mon_errors++;
                    end
                    assert (o_tx.last == exp_last)
                    else
                    begin
                        show_mismatch("o_tx.last", 32'(o_tx.last), 32'(exp_last));
                        mon_errors++;
                    end
                end
                idle_run   = o_tx_valid ? 0 : idle_run + 1;
                prev_valid = o_tx_valid;
                prev_last  = o_tx.last;
            end
        end
    end

    ////////////////////
    // stimulus
    ////////////////////

    initial
    begin
        int                       errs_before;
        int                       n;
        logic [`MAC_TX_CNT_W-1:0] cnt_before;
        seed         = 47642;
        mon_errors   = 0;
        stim_errors  = 0;
        tests_run    = 0;
        sent_frames  = 0;
        cycles       = 0;
        idle_run     = 0;
        frames_seen  = 0;
        min_gap      = int'(`MAC_TX_IPG_DEFAULT);
        hold_low     = 1'b0;
        prev_valid   = 1'b0;
        prev_last    = 1'b0;
        i_send       = '0;
        i_send_valid = 1'b0;
        i_tx_ready   = 1'b1;
        i_ipg        = '0;
        i_rst        = 1'b1;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;

        errs_before = 0;
        check_value("o_tx_valid", 32'(o_tx_valid), 32'd0);
        check_value("o_send_ready", 32'(o_send_ready), 32'd1);
        check_value("o_tx_frames_cnt", 32'(o_tx_frames_cnt), 32'd0);
        check_value("o_tx_fragment_cnt", 32'(o_tx_fragment_cnt), 32'd0);
        finish_test("reset state", errs_before);

        // back to back, several frames queued at once
        errs_before = mon_errors + stim_errors;
        for (n = 0; n < 6; n++)
            send_frame(rand_len(), SMD_E, 8'h00, 1'b1);
        wait_drain();
        finish_test("final frames, start smd", errs_before);

        errs_before = mon_errors + stim_errors;
        send_frame(rand_len(), SMD_S0, 8'h00, 1'b0);
        wait_drain();
        finish_test("mcrc frame", errs_before);

        errs_before = mon_errors + stim_errors;
        cnt_before  = o_tx_fragment_cnt;
        send_frame(rand_len(), `MAC_TX_SMD_C1, 8'h03, 1'b1);
        wait_drain();
        check_value("o_tx_fragment_cnt", 32'(o_tx_fragment_cnt), 32'(cnt_before + 1'b1));
        send_frame(rand_len(), SMD_E, 8'h00, 1'b1);
        wait_drain();
        check_value("o_tx_fragment_cnt", 32'(o_tx_fragment_cnt), 32'(cnt_before + 1'b1));
        finish_test("continuation smd", errs_before);

        errs_before = mon_errors + stim_errors;
        load_gap(8'(MAX_GAP));
        send_frame(rand_len(), SMD_E, 8'h00, 1'b1);
        send_frame(rand_len(), SMD_E, 8'h00, 1'b1);
        wait_drain();
        // line idle, nothing may start until ready returns
        i_tx_ready = 1'b0;
        hold_low   = 1'b1;
        cnt_before = o_tx_frames_cnt;
        for (n = 0; n < 3; n++)
            send_frame(rand_len(), SMD_E, 8'h00, 1'b1);
        repeat (40) @(posedge i_clk);
        #1;
        check_value("o_tx_frames_cnt", 32'(o_tx_frames_cnt), 32'(cnt_before));
        i_tx_ready = 1'b1;
        hold_low   = 1'b0;
        wait_drain();
        check_value("o_tx_frames_cnt", 32'(o_tx_frames_cnt), 32'(sent_frames));
        finish_test("gap and back-pressure", errs_before);

        $display("tests run: %0d, frames sent: %0d, checks failed: %0d",
                 tests_run, sent_frames, mon_errors + stim_errors);
        if (mon_errors + stim_errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

//--- mac_tx.f
+incdir+common
common/mac_tx_frame_pkg.sv
common/mac_tx_stream_pkg.sv
hw/sync_fifo.sv
hw/mac_tx_ingress.sv
framer/crc32_d8.sv
framer/mac_tx_framer.sv
hw/mac_tx.sv
verification/mac_tx_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mac_tx_tb
FILELIST  := mac_tx.f
OBJ_DIR   := obj_dir

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -q '^>>> PASS$$'

clean:
	rm -rf $(OBJ_DIR)
